// File: vlog.f
+incdir+verilog
verilog/dsp_data_pkg.sv
verilog/dsp_ctrl_pkg.sv
verilog/dsp_input_regs.sv
verilog/dsp_op_decode.sv
verilog/dsp_mult_stage.sv
verilog/dsp_alu.sv
verilog/dsp_result.sv
verilog/dsp_slice.sv
verification/dsp_slice_sva.sv
verification/dsp_slice_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module dsp_slice_tb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vdsp_slice_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: verification/dsp_slice_tb.sv
// Table-driven testbench for the DSP slice with a ce-gated pipeline reference model
`timescale 1ns/100ps
`default_nettype none

`include "dsp_macros.svh"

module dsp_slice_tb;

	typedef struct packed {
		dsp_data_pkg::a_data_t a;
		dsp_data_pkg::b_data_t b;
		dsp_data_pkg::c_data_t c;
		dsp_data_pkg::d_data_t d;
		dsp_data_pkg::c_data_t pcin;
		logic                  carry_in;
		logic [3:0]            opmode;
		logic [1:0]            alumode;
		logic [1:0]            inmode;
		logic                  ce;
	} stim_t;

	// Output register state expected after an edge
	typedef struct packed {
		dsp_data_pkg::c_data_t p;
		logic                  carryout;
		logic                  pd;
		logic                  pbd;
	} result_t;

	logic                  clk;
	logic                  rst_n;
	stim_t                 drv;
	dsp_data_pkg::c_data_t p;
	dsp_data_pkg::c_data_t pcout;
	logic                  carryout;
	logic                  patterndetect;
	logic                  patternbdetect;

	stim_t   rows[$];
	string   names[$];
	// Row indices in flight with the oldest first
	// A zeroed stage holds -1
	int      pipe[$];
	result_t exp_q;
	string   exp_name;
	int      errors;
	int      others;
	int      checks;
	int      pending;
	int      cycles;

	dsp_slice i_dsp_slice (
		.clk(clk), .rst_n(rst_n), .ce(drv.ce), .a(drv.a), .b(drv.b), .c(drv.c), .d(drv.d),
		.pcin(drv.pcin), .carry_in(drv.carry_in), .opmode(drv.opmode), .alumode(drv.alumode),
		.inmode(drv.inmode), .p(p), .pcout(pcout), .carryout(carryout),
		.patterndetect(patterndetect), .patternbdetect(patternbdetect)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
	end

	function automatic dsp_data_pkg::c_data_t rand48();
		logic [63:0] v;
		v = {$urandom, $urandom};
		return v[47:0];
	endfunction

	// Result of one operation leaving stage 2 with the pcin and p seen at that edge
	function automatic result_t exec_op(stim_t s, dsp_data_pkg::c_data_t pcin_now,
		dsp_data_pkg::c_data_t p_now);
		dsp_data_pkg::ad_data_t a27;
		dsp_data_pkg::ad_data_t ad;
		longint                 prod;
		dsp_data_pkg::c_data_t  x;
		dsp_data_pkg::c_data_t  z;
		logic [48:0]            wide;
		result_t                r;
		a27 = s.a[26:0];
		case (s.inmode)
			2'd1:    ad = s.d + a27;
			2'd2:    ad = s.d - a27;
			default: ad = a27;
		endcase
		prod = longint'($signed(ad)) * longint'($signed(s.b));
		case (s.opmode[1:0])
			2'd1:    x = prod[47:0];
			2'd2:    x = {s.a, s.b};
			2'd3:    x = p_now;
			default: x = '0;
		endcase
		case (s.opmode[3:2])
			2'd1:    z = s.c;
			2'd2:    z = p_now;
			2'd3:    z = pcin_now;
			default: z = '0;
		endcase
		case (s.alumode)
			2'd0:    wide = {1'b0, z} + {1'b0, x} + 49'(s.carry_in);
			2'd1:    wide = {1'b0, z} - ({1'b0, x} + 49'(s.carry_in));
			2'd2:    wide = {1'b0, z & x};
			default: wide = {1'b0, z ^ x};
		endcase
		r.p        = wide[47:0];
		r.carryout = wide[48];
		r.pd       = &((r.p ~^ s.c) | `DSP_PATTERN_MASK);
		r.pbd      = &((r.p ^ s.c) | `DSP_PATTERN_MASK);
		return r;
	endfunction

	task automatic add_row(string name, dsp_data_pkg::a_data_t a, dsp_data_pkg::b_data_t b,
		dsp_data_pkg::c_data_t c, dsp_data_pkg::d_data_t d, logic [3:0] opmode,
		logic [1:0] alumode, logic [1:0] inmode, logic cin, logic ce);
		stim_t s;
		s = {a, b, c, d, rand48(), cin, opmode, alumode, inmode, ce};
		rows.push_back(s);
		names.push_back(name);
	endtask

	// Advance the model by the coming rising edge with the inputs now driven
	task automatic model_edge(int idx);
		stim_t front;
		if (drv.ce) begin
			front    = (pipe[0] < 0) ? '0 : rows[pipe[0]];
			exp_q    = exec_op(front, drv.pcin, exp_q.p);
			exp_name = (pipe[0] < 0) ? "idle" : names[pipe[0]];
			if (pipe[0] >= 0)
				pending--;
			void'(pipe.pop_front());
			pipe.push_back(idx);
			if (idx >= 0)
				pending++;
		end
	endtask

	task automatic mismatch(string sig, dsp_data_pkg::c_data_t e, dsp_data_pkg::c_data_t a);
		errors++;
		$display("MISMATCH %s %s expected %h actual %h", exp_name, sig, e, a);
	endtask

	task automatic check_outputs();
		checks++;
		assert (p === exp_q.p) else mismatch("p", exp_q.p, p);
		assert (pcout === exp_q.p) else mismatch("pcout", exp_q.p, pcout);
		assert (carryout === exp_q.carryout)
			else mismatch("carryout", exp_q.carryout, carryout);
		assert (patterndetect === exp_q.pd)
			else mismatch("patterndetect", exp_q.pd, patterndetect);
		assert (patternbdetect === exp_q.pbd)
			else mismatch("patternbdetect", exp_q.pbd, patternbdetect);
	endtask

	task automatic build_table();
		dsp_data_pkg::c_data_t r1;
		dsp_data_pkg::c_data_t r2;
		dsp_data_pkg::c_data_t r3;
		dsp_data_pkg::c_data_t r4;
		r1 = rand48();
		r2 = rand48();
		r3 = rand48();
		r4 = rand48();
		// Products through each pre-adder mode and inmode 3 as A only
		add_row("mul_pre_a", -30'sd7, 18'd123, '0, '0, 4'b0001, 2'd0, 2'd0, 1'b0, 1'b1);
		add_row("mul_pre_a_neg", 30'd1000, -18'sd5, '0, '0, 4'b0001, 2'd0, 2'd3, 1'b0, 1'b1);
		add_row("mul_d_plus_a", 30'd50, -18'sd77, '0, -27'sd300, 4'b0001, 2'd0, 2'd1, 1'b0, 1'b1);
		add_row("mul_d_minus_a", r1[29:0], r2[17:0], '0, r3[26:0], 4'b0001, 2'd0, 2'd2, 1'b0, 1'b1);
		add_row("mac_load", 30'd100, 18'd3, '0, '0, 4'b0001, 2'd0, 2'd0, 1'b0, 1'b1);
		add_row("mac_acc_1", 30'd7, -18'sd11, '0, '0, 4'b1001, 2'd0, 2'd0, 1'b0, 1'b1);
		add_row("mac_acc_2", 30'd900, 18'd900, '0, '0, 4'b1001, 2'd0, 2'd0, 1'b1, 1'b1);
		add_row("add_c_ab", r1[29:0], r2[17:0], r3, '0, 4'b0110, 2'd0, 2'd0, 1'b1, 1'b1);
		add_row("sub_c_ab", r2[29:0], r4[17:0], r1, '0, 4'b0110, 2'd1, 2'd0, 1'b1, 1'b1);
		add_row("add_pcin_ab", r3[29:0], r1[17:0], r4, '0, 4'b1110, 2'd0, 2'd0, 1'b0, 1'b1);
		add_row("sub_pcin_ab", r4[29:0], r3[17:0], r2, '0, 4'b1110, 2'd1, 2'd0, 1'b1, 1'b1);
		add_row("add_carry", 30'd0, 18'd1, {48{1'b1}}, '0, 4'b0110, 2'd0, 2'd0, 1'b0, 1'b1);
		add_row("and_c_ab", r1[29:0], r3[17:0], r2, '0, 4'b0110, 2'd2, 2'd0, 1'b1, 1'b1);
		add_row("xor_c_ab", r4[29:0], r2[17:0], r3, '0, 4'b0110, 2'd3, 2'd0, 1'b1, 1'b1);
		// Differences only in the masked low 16 bits
		add_row("pat_masked", 30'd0, 18'h1234, 48'h1234_5678_0000, '0, 4'b0110, 2'd0, 2'd0, 1'b1,
			1'b1);
		add_row("pat_inverse", 30'h3FFF_FFFF, 18'h3_FFFF, r1, '0, 4'b0110, 2'd3, 2'd0, 1'b0, 1'b1);
		add_row("pat_inv_masked", 30'h3FFF_FFFF, 18'h3_5A5A, r2, '0, 4'b0110, 2'd3, 2'd0, 1'b0,
			1'b1);
		add_row("stall_op_1", 30'd3, 18'd5, '0, '0, 4'b1001, 2'd0, 2'd0, 1'b0, 1'b1);
		add_row("stall_hold_1", r1[29:0], r2[17:0], r3, r4[26:0], 4'b0110, 2'd1, 2'd1, 1'b1, 1'b0);
		add_row("stall_hold_2", r2[29:0], r3[17:0], r4, r1[26:0], 4'b1111, 2'd3, 2'd2, 1'b1, 1'b0);
		add_row("stall_op_2", 30'd2, 18'd8, '0, '0, 4'b1001, 2'd0, 2'd0, 1'b0, 1'b1);
		add_row("stall_op_3", 30'd1, 18'd1, '0, '0, 4'b1011, 2'd0, 2'd0, 1'b0, 1'b1);
	endtask

	initial begin
		void'($urandom(32'h4044_3c1b));
		drv      = '0;
		errors   = 0;
		others   = 0;
		checks   = 0;
		pending  = 0;
		pipe.push_back(-1);
		pipe.push_back(-1);
		exp_q    = '0;
		exp_name = "reset";
		build_table();

		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!rst_n && cycles < 20);
		if (!rst_n) begin
			$display("Reset was still asserted after 20 cycles");
			others++;
		end
		@(negedge clk);
		check_outputs();

		foreach (rows[i]) begin
			drv = rows[i];
			model_edge(i);
			@(negedge clk);
			check_outputs();
		end

		// Idle operations push the last rows out
		drv    = '0;
		drv.ce = 1'b1;
		cycles = 0;
		while (pending > 0 && cycles < 10) begin
			model_edge(-1);
			@(negedge clk);
			check_outputs();
			cycles++;
		end
		if (pending > 0) begin
			$display("Pipeline still held %0d operations after 10 idle cycles", pending);
			others++;
		end

		$display("Checks %0d, mismatches %0d, other errors %0d", checks, errors, others);
		if (errors == 0 && others == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/dsp_slice_sva.sv
// Concurrent assertions on the DSP slice outputs and their bind to the top level
`timescale 1ns/100ps
`default_nettype none

module dsp_slice_sva (
	input wire logic                  clk,
	input wire logic                  rst_n,
	input wire logic                  ce,
	input wire dsp_data_pkg::c_data_t p,
	input wire dsp_data_pkg::c_data_t pcout,
	input wire logic                  patterndetect,
	input wire logic                  patternbdetect
);

	// Output registers clear as soon as reset goes low
	reset_zero: assert property (@(posedge clk)
		!rst_n |-> (p == '0 && !patterndetect && !patternbdetect))
		else $error("P or a pattern flag is not zero during reset");

	stall_hold: assert property (@(posedge clk) disable iff (!rst_n) !ce |=> $stable(p))
		else $error("P changed after an edge with ce low");

	flags_exclusive: assert property (@(posedge clk) !(patterndetect && patternbdetect))
		else $error("Pattern and inverted pattern flags are set together");

	pcout_copy: assert property (@(posedge clk) pcout == p)
		else $error("PCOUT differs from P");

endmodule

bind dsp_slice dsp_slice_sva i_dsp_slice_sva (
	.clk(clk), .rst_n(rst_n), .ce(ce), .p(p), .pcout(pcout),
	.patterndetect(patterndetect), .patternbdetect(patternbdetect)
);

`default_nettype wire

// File: verilog/dsp_slice.sv
// DSP slice top level connecting decode, input registers, multiplier, ALU and result stages
`timescale 1ns/100ps
`default_nettype none

module dsp_slice (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    ce,
	input  wire dsp_data_pkg::a_data_t   a,
	input  wire dsp_data_pkg::b_data_t   b,
	input  wire dsp_data_pkg::c_data_t   c,
	input  wire dsp_data_pkg::d_data_t   d,
	input  wire dsp_data_pkg::c_data_t   pcin,
	input  wire logic                    carry_in,
	input  wire logic [3:0]              opmode,
	input  wire logic [1:0]              alumode,
	input  wire logic [1:0]              inmode,
	output dsp_data_pkg::c_data_t        p,
	output dsp_data_pkg::c_data_t        pcout,
	output logic                         carryout,
	output logic                         patterndetect,
	output logic                         patternbdetect
);

	dsp_ctrl_pkg::dsp_ctrl_t       ctrl_s1;
	dsp_ctrl_pkg::dsp_ctrl_t       ctrl_s2;
	dsp_ctrl_pkg::preadd_e         preadd;
	dsp_data_pkg::dsp_operands_t   operands_s1;
	dsp_data_pkg::dsp_operands_t   operands_s2;
	dsp_data_pkg::m_data_t         m_s2;
	dsp_data_pkg::c_data_t         sum;
	logic                          carry;

	// Stage 1, controls and operands
	dsp_op_decode i_dsp_op_decode (
		.clk(clk), .rst_n(rst_n), .ce(ce),
		.opmode(opmode), .alumode(alumode), .inmode(inmode),
		.ctrl_s1(ctrl_s1), .preadd(preadd)
	);

	dsp_input_regs i_dsp_input_regs (
		.clk(clk), .rst_n(rst_n), .ce(ce),
		.a(a), .b(b), .c(c), .d(d), .carry_in(carry_in), .preadd(preadd),
		.operands_s1(operands_s1)
	);

	// Stage 2, product and ALU
	dsp_mult_stage i_dsp_mult_stage (
		.clk(clk), .rst_n(rst_n), .ce(ce),
		.operands_s1(operands_s1), .ctrl_s1(ctrl_s1),
		.m_s2(m_s2), .operands_s2(operands_s2), .ctrl_s2(ctrl_s2)
	);

	dsp_alu i_dsp_alu (
		.m_s2(m_s2), .operands_s2(operands_s2), .ctrl_s2(ctrl_s2),
		.p(p), .pcin(pcin),
		.sum(sum), .carry(carry)
	);

	// Stage 3, output register
	dsp_result i_dsp_result (
		.clk(clk), .rst_n(rst_n), .ce(ce),
		.sum(sum), .carry(carry), .c_s2(operands_s2.c),
		.p(p), .carryout(carryout),
		.patterndetect(patterndetect), .patternbdetect(patternbdetect)
	);

	assign pcout = p;

endmodule

`default_nettype wire

// File: verilog/dsp_result.sv
// P and carry-out output registers with masked pattern and inverted pattern detection
`timescale 1ns/100ps
`default_nettype none

`include "dsp_macros.svh"

module dsp_result (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    ce,
	input  wire dsp_data_pkg::c_data_t   sum,
	input  wire logic                    carry,
	input  wire dsp_data_pkg::c_data_t   c_s2,
	output dsp_data_pkg::c_data_t        p,
	output logic                         carryout,
	output logic                         patterndetect,
	output logic                         patternbdetect
);

	logic                  match;
	logic                  match_inv;

	// Only bits clear in the mask are compared
	assign match     = ((sum ^ c_s2) & ~`DSP_PATTERN_MASK) == '0;
	assign match_inv = ((sum ^ ~c_s2) & ~`DSP_PATTERN_MASK) == '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			p              <= '0;
			carryout       <= 1'b0;
			patterndetect  <= 1'b0;
			patternbdetect <= 1'b0;
		end else if (ce) begin
			p              <= sum;
			carryout       <= carry;
			patterndetect  <= match;
			patternbdetect <= match_inv;
		end
	end

endmodule

`default_nettype wire

// File: verilog/dsp_alu.sv
// X and Z operand multiplexers and the 48-bit add, subtract, AND and XOR ALU
`timescale 1ns/100ps
`default_nettype none

`include "dsp_macros.svh"

module dsp_alu (
	input  wire dsp_data_pkg::m_data_t         m_s2,
	input  wire dsp_data_pkg::dsp_operands_t   operands_s2,
	input  wire dsp_ctrl_pkg::dsp_ctrl_t       ctrl_s2,
	input  wire dsp_data_pkg::c_data_t         p,
	input  wire dsp_data_pkg::c_data_t         pcin,
	output dsp_data_pkg::c_data_t              sum,
	output logic                               carry
);

	dsp_data_pkg::c_data_t m_ext;
	dsp_data_pkg::c_data_t x_op;
	dsp_data_pkg::c_data_t z_op;

	// 49 bits so the top bit is the carry
	logic [`DSP_C_W:0] x_wide;
	logic [`DSP_C_W:0] z_wide;
	logic [`DSP_C_W:0] arith;

	// Product sign extended to the ALU width
	assign m_ext = {{(`DSP_C_W-`DSP_M_W){m_s2[`DSP_M_W-1]}}, m_s2};

	always_comb begin
		case (ctrl_s2.x_sel)
			dsp_ctrl_pkg::X_M:  x_op = m_ext;
			dsp_ctrl_pkg::X_AB: x_op = operands_s2.ab;
			dsp_ctrl_pkg::X_P:  x_op = p;
			default:            x_op = '0;
		endcase
	end

	always_comb begin
		case (ctrl_s2.z_sel)
			dsp_ctrl_pkg::Z_C:    z_op = operands_s2.c;
			dsp_ctrl_pkg::Z_P:    z_op = p;
			dsp_ctrl_pkg::Z_PCIN: z_op = pcin;
			default:              z_op = '0;
		endcase
	end

	assign x_wide = {1'b0, x_op};
	assign z_wide = {1'b0, z_op};

	// Subtract takes the carry in together with X
	always_comb begin
		if (ctrl_s2.alu_op == dsp_ctrl_pkg::ALU_SUB) begin
			arith = z_wide - (x_wide + operands_s2.carry_in);
		end else begin
			arith = z_wide + x_wide + operands_s2.carry_in;
		end
	end

	always_comb begin
		case (ctrl_s2.alu_op)
			dsp_ctrl_pkg::ALU_AND: begin
				sum   = z_op & x_op;
				carry = 1'b0;
			end
			dsp_ctrl_pkg::ALU_XOR: begin
				sum   = z_op ^ x_op;
				carry = 1'b0;
			end
			default: begin
				sum   = arith[`DSP_C_W-1:0];
				carry = arith[`DSP_C_W];
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/dsp_mult_stage.sv
// Signed 27x18 multiplier, M register and the stage 2 operand and control registers
`timescale 1ns/100ps
`default_nettype none

module dsp_mult_stage (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          ce,
	input  wire dsp_data_pkg::dsp_operands_t   operands_s1,
	input  wire dsp_ctrl_pkg::dsp_ctrl_t       ctrl_s1,
	output dsp_data_pkg::m_data_t              m_s2,
	output dsp_data_pkg::dsp_operands_t        operands_s2,
	output dsp_ctrl_pkg::dsp_ctrl_t            ctrl_s2
);

	dsp_data_pkg::m_data_t product;

	// Both operands signed, result fits 45 bits
	assign product = $signed(operands_s1.ad) * $signed(operands_s1.b);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_s2        <= '0;
			operands_s2 <= '0;
			ctrl_s2     <= '0;
		end else if (ce) begin
			m_s2                 <= product;
			// ad and b are consumed by the multiplier
			operands_s2.ad       <= '0;
			operands_s2.b        <= '0;
			operands_s2.c        <= operands_s1.c;
			operands_s2.ab       <= operands_s1.ab;
			operands_s2.carry_in <= operands_s1.carry_in;
			ctrl_s2              <= ctrl_s1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/dsp_op_decode.sv
// Stage 1 OPMODE, ALUMODE and INMODE registers and their decode into control enums
`timescale 1ns/100ps
`default_nettype none

module dsp_op_decode (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   ce,
	input  wire logic [3:0]             opmode,
	input  wire logic [1:0]             alumode,
	input  wire logic [1:0]             inmode,
	output dsp_ctrl_pkg::dsp_ctrl_t     ctrl_s1,
	output dsp_ctrl_pkg::preadd_e       preadd
);

	logic [3:0] opmode_q;
	logic [1:0] alumode_q;
	logic [1:0] inmode_q;

	// Zero after reset decodes to X_ZERO, Z_ZERO and ALU_ADD
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			opmode_q  <= '0;
			alumode_q <= '0;
			inmode_q  <= '0;
		end else if (ce) begin
			opmode_q  <= opmode;
			alumode_q <= alumode;
			inmode_q  <= inmode;
		end
	end

	assign ctrl_s1.x_sel  = dsp_ctrl_pkg::x_sel_e'(opmode_q[1:0]);
	assign ctrl_s1.z_sel  = dsp_ctrl_pkg::z_sel_e'(opmode_q[3:2]);
	assign ctrl_s1.alu_op = dsp_ctrl_pkg::alu_op_e'(alumode_q);

	// Pre-adder mode is used in this stage
	always_comb begin
		case (inmode_q)
			2'd1:    preadd = dsp_ctrl_pkg::PRE_D_PLUS_A;
			2'd2:    preadd = dsp_ctrl_pkg::PRE_D_MINUS_A;
			default: preadd = dsp_ctrl_pkg::PRE_A;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/dsp_input_regs.sv
// Stage 1 A, B, C, D and carry-in registers with the signed pre-adder
`timescale 1ns/100ps
`default_nettype none

`include "dsp_macros.svh"

module dsp_input_regs (
	input  wire logic                        clk,
	input  wire logic                        rst_n,
	input  wire logic                        ce,
	input  wire dsp_data_pkg::a_data_t       a,
	input  wire dsp_data_pkg::b_data_t       b,
	input  wire dsp_data_pkg::c_data_t       c,
	input  wire dsp_data_pkg::d_data_t       d,
	input  wire logic                        carry_in,
	input  wire dsp_ctrl_pkg::preadd_e       preadd,
	output dsp_data_pkg::dsp_operands_t      operands_s1
);

	dsp_data_pkg::a_data_t  a_q;
	dsp_data_pkg::b_data_t  b_q;
	dsp_data_pkg::c_data_t  c_q;
	dsp_data_pkg::d_data_t  d_q;
	logic                   carry_in_q;

	// Low bits of A feed the pre-adder
	dsp_data_pkg::ad_data_t a_low;
	dsp_data_pkg::ad_data_t ad;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			a_q        <= '0;
			b_q        <= '0;
			c_q        <= '0;
			d_q        <= '0;
			carry_in_q <= 1'b0;
		end else if (ce) begin
			a_q        <= a;
			b_q        <= b;
			c_q        <= c;
			d_q        <= d;
			carry_in_q <= carry_in;
		end
	end

	assign a_low = a_q[`DSP_AD_W-1:0];

	// Two's complement add and subtract wrap at 27 bits
	always_comb begin
		case (preadd)
			dsp_ctrl_pkg::PRE_D_PLUS_A:  ad = d_q + a_low;
			dsp_ctrl_pkg::PRE_D_MINUS_A: ad = d_q - a_low;
			default:                     ad = a_low;
		endcase
	end

	assign operands_s1.ad       = ad;
	assign operands_s1.b        = b_q;
	assign operands_s1.c        = c_q;
	assign operands_s1.ab       = {a_q, b_q};
	assign operands_s1.carry_in = carry_in_q;

endmodule

`default_nettype wire

// File: verilog/dsp_ctrl_pkg.sv
// Operand select, ALU operation and pre-adder mode enums, and the decoded control bundle
`default_nettype none

package dsp_ctrl_pkg;

	// X multiplexer, from opmode[1:0]
	typedef enum logic [1:0] {
		X_ZERO = 2'd0,
		X_M    = 2'd1,
		X_AB   = 2'd2,
		X_P    = 2'd3
	} x_sel_e;

	// Z multiplexer, from opmode[3:2]
	typedef enum logic [1:0] {
		Z_ZERO = 2'd0,
		Z_C    = 2'd1,
		Z_P    = 2'd2,
		Z_PCIN = 2'd3
	} z_sel_e;

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_AND = 2'd2,
		ALU_XOR = 2'd3
	} alu_op_e;

	// Pre-adder function, inmode code 3 falls back to PRE_A
	typedef enum logic [1:0] {
		PRE_A         = 2'd0,
		PRE_D_PLUS_A  = 2'd1,
		PRE_D_MINUS_A = 2'd2
	} preadd_e;

	// Controls that travel with the operation down to the ALU
	typedef struct packed {
		x_sel_e  x_sel;
		z_sel_e  z_sel;
		alu_op_e alu_op;
	} dsp_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/dsp_data_pkg.sv
// Data width typedefs and the operand bundle passed along the pipeline
`default_nettype none

`include "dsp_macros.svh"

package dsp_data_pkg;

	typedef logic [`DSP_A_W-1:0]  a_data_t;
	typedef logic [`DSP_B_W-1:0]  b_data_t;
	typedef logic [`DSP_C_W-1:0]  c_data_t;
	typedef logic [`DSP_D_W-1:0]  d_data_t;
	typedef logic [`DSP_AD_W-1:0] ad_data_t;
	typedef logic [`DSP_M_W-1:0]  m_data_t;

	// Operands of one operation, ab is A:B as a 48-bit ALU operand
	typedef struct packed {
		ad_data_t ad;
		b_data_t  b;
		c_data_t  c;
		c_data_t  ab;
		logic     carry_in;
	} dsp_operands_t;

endpackage

`default_nettype wire

// File: verilog/dsp_macros.svh
// Operand, product and result widths and the pattern detect mask of the DSP slice
`ifndef DSP_MACROS_SVH
`define DSP_MACROS_SVH

// A input, stored in full for the A:B concatenation
`define DSP_A_W 30

// B input, also the multiplier B operand
`define DSP_B_W 18

// C input, P output, PCIN and the ALU datapath
`define DSP_C_W 48

// D input of the pre-adder
`define DSP_D_W 27

// Pre-adder result and multiplier A operand
`define DSP_AD_W 27

// Full signed product of 27 by 18
`define DSP_M_W 45

// A set bit is a don't care in the pattern compare
`define DSP_PATTERN_MASK 48'h0000_0000_FFFF

`endif
